// ==== build.f ====
src/ghrd_pkg.sv
src/key_debounce.sv
src/reset_req_pulse.sv
src/heartbeat_led.sv
src/pio_axil_regs.sv
src/fpga_ghrd_top.sv
test/ghrd_checker.sv
test/tb_fpga_ghrd_top.sv

// ==== src/fpga_ghrd_top.sv ====
`default_nettype none

module fpga_ghrd_top #(
  parameter int debounce_cycles = ghrd_pkg::DEBOUNCE_CYCLES,
  parameter int hb_half_period  = ghrd_pkg::HEARTBEAT_HALF_PERIOD
) (
  input  logic                      fpga_clk_50,
  input  logic                      hps_fpga_reset_n,
  input  ghrd_pkg::key_t            key,          // active low
  input  ghrd_pkg::sw_t             sw,
  output logic [$bits(ghrd_pkg::led_t):0] ledr,   // bit 0 heartbeat
  output ghrd_pkg::stm_events_t     stm_events,
  output logic                      cold_reset_req,
  output logic                      warm_reset_req,
  output logic                      debug_reset_req,
  input  ghrd_pkg::axil_addr_t      s_axil_awaddr,
  input  logic                      s_axil_awvalid,
  output logic                      s_axil_awready,
  input  ghrd_pkg::axil_data_t      s_axil_wdata,
  input  logic                      s_axil_wvalid,
  output logic                      s_axil_wready,
  output ghrd_pkg::axil_resp_e      s_axil_bresp,
  output logic                      s_axil_bvalid,
  input  logic                      s_axil_bready,
  input  ghrd_pkg::axil_addr_t      s_axil_araddr,
  input  logic                      s_axil_arvalid,
  output logic                      s_axil_arready,
  output ghrd_pkg::axil_data_t      s_axil_rdata,
  output ghrd_pkg::axil_resp_e      s_axil_rresp,
  output logic                      s_axil_rvalid,
  input  logic                      s_axil_rready
);

  import ghrd_pkg::*;

  key_t       buttons;     // debounced, pressed is 1
  led_t       led;
  reset_req_t reset_req;
  logic       heartbeat;

  assign ledr       = {led, heartbeat};
  assign stm_events = {{STM_PAD_BITS{1'b0}}, sw, led, buttons};   // trace word

  // ====================
  // blocks
  // ====================
  key_debounce #(.debounce_cycles(debounce_cycles)) key_debounce_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .key              (key),
    .buttons          (buttons)
  );

  pio_axil_regs pio_axil_regs_i (.*);   // names match one to one

  heartbeat_led #(.hb_half_period(hb_half_period)) heartbeat_led_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .led              (heartbeat)
  );

  // one stretcher per reset kind
  reset_req_pulse #(.pulse_cycles(COLD_PULSE_CYCLES)) cold_pulse_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (reset_req[REQ_COLD]),
    .pulse            (cold_reset_req)
  );

  reset_req_pulse #(.pulse_cycles(WARM_PULSE_CYCLES)) warm_pulse_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (reset_req[REQ_WARM]),
    .pulse            (warm_reset_req)
  );

  reset_req_pulse #(.pulse_cycles(DEBUG_PULSE_CYCLES)) debug_pulse_i (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (reset_req[REQ_DEBUG]),
    .pulse            (debug_reset_req)
  );

endmodule

`default_nettype wire

// ==== src/ghrd_pkg.sv ====
`default_nettype none

package ghrd_pkg;

  // ====================
  // bus types
  // ====================
  typedef logic [3:0]  axil_addr_t;   // byte address, four regs
  typedef logic [31:0] axil_data_t;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axil_resp_e;

  // register map
  typedef enum logic [3:0] {
    REG_LED       = 4'h0,
    REG_SW        = 4'h4,   // read only
    REG_BUTTON    = 4'h8,   // read only, debounced
    REG_RESET_REQ = 4'hC
  } reg_addr_e;

  // ====================
  // board side types
  // ====================
  typedef logic [8:0]  led_t;         // ledr[9:1]
  typedef logic [9:0]  sw_t;
  typedef logic [3:0]  key_t;
  typedef logic [2:0]  reset_req_t;   // cold, warm, debug
  typedef logic [27:0] stm_events_t;

  typedef enum logic {
    IDLE = 1'b0,
    BUSY = 1'b1
  } pulse_state_e;

  localparam int DEBOUNCE_CYCLES       = 50000;      // 1 ms at 50 MHz
  localparam int HEARTBEAT_HALF_PERIOD = 25000000;   // 1 Hz blink

  // reset request pulse widths in clocks
  localparam int COLD_PULSE_CYCLES  = 6;
  localparam int WARM_PULSE_CYCLES  = 2;
  localparam int DEBUG_PULSE_CYCLES = 32;

  localparam int REQ_COLD  = 0;
  localparam int REQ_WARM  = 1;
  localparam int REQ_DEBUG = 2;

  // zero bits above sw in the trace word
  localparam int STM_PAD_BITS = $bits(stm_events_t) - $bits(sw_t) - $bits(led_t) - $bits(key_t);

endpackage

`default_nettype wire

// ==== src/heartbeat_led.sv ====
`default_nettype none

module heartbeat_led #(
  parameter int hb_half_period = ghrd_pkg::HEARTBEAT_HALF_PERIOD
) (
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  output logic led
);

  localparam int cnt_w = $clog2(hb_half_period + 1);
  localparam logic [cnt_w-1:0] cnt_wrap = cnt_w'(hb_half_period - 1);

  logic [cnt_w-1:0] cnt;   // half period counter

  // blinking ledr[0] shows the fabric is clocked and out of reset
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      cnt <= '0;
      led <= 1'b0;
    end
    else if (cnt == cnt_wrap)
    begin
      cnt <= '0;
      led <= ~led;   // flip once per half period
    end
    else
      cnt <= cnt + 1'b1;
  end

endmodule

`default_nettype wire

// ==== src/key_debounce.sv ====
`default_nettype none

module key_debounce #(
  parameter int debounce_cycles = ghrd_pkg::DEBOUNCE_CYCLES
) (
  input  logic          fpga_clk_50,
  input  logic          hps_fpga_reset_n,
  input  ghrd_pkg::key_t key,       // raw, active low
  output ghrd_pkg::key_t buttons    // debounced, pressed is 1
);

  import ghrd_pkg::*;

  localparam int cnt_w = $clog2(debounce_cycles + 1);
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(debounce_cycles - 1);

  key_t             key_meta;   // first sync stage
  key_t             key_sync;
  key_t             pressed;
  logic [cnt_w-1:0] cnt [$bits(key_t)];

  // invert so a held key reads as 1
  assign pressed = ~key_sync;

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      key_meta <= '1;   // keys idle high
      key_sync <= '1;
      buttons  <= '0;
      for (int i = 0; i < $bits(key_t); i++)
      begin
        cnt[i] <= '0;
      end
    end
    else
    begin
      key_meta <= key;
      key_sync <= key_meta;
      for (int i = 0; i < $bits(key_t); i++)
      begin
        if (pressed[i] == buttons[i])
          cnt[i] <= '0;                  // agrees or bounced back, restart
        else if (cnt[i] == cnt_last)
        begin
          // stable long enough
          buttons[i] <= pressed[i];
          cnt[i]     <= '0;
        end
        else
          cnt[i] <= cnt[i] + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/pio_axil_regs.sv ====
`default_nettype none

module pio_axil_regs (
  input  logic                 fpga_clk_50,
  input  logic                 hps_fpga_reset_n,
  // write address
  input  ghrd_pkg::axil_addr_t s_axil_awaddr,
  input  logic                 s_axil_awvalid,
  output logic                 s_axil_awready,
  // write data
  input  ghrd_pkg::axil_data_t s_axil_wdata,
  input  logic                 s_axil_wvalid,
  output logic                 s_axil_wready,
  // write response
  output ghrd_pkg::axil_resp_e s_axil_bresp,
  output logic                 s_axil_bvalid,
  input  logic                 s_axil_bready,
  // read address
  input  ghrd_pkg::axil_addr_t s_axil_araddr,
  input  logic                 s_axil_arvalid,
  output logic                 s_axil_arready,
  // read data
  output ghrd_pkg::axil_data_t s_axil_rdata,
  output ghrd_pkg::axil_resp_e s_axil_rresp,
  output logic                 s_axil_rvalid,
  input  logic                 s_axil_rready,
  // board side
  input  ghrd_pkg::sw_t        sw,
  input  ghrd_pkg::key_t       buttons,
  output ghrd_pkg::led_t       led,
  output ghrd_pkg::reset_req_t reset_req
);

  import ghrd_pkg::*;

  logic       wr_hs;     // aw and w accepted together
  logic       rd_hs;
  axil_resp_e wr_resp;
  axil_data_t rd_data;
  axil_resp_e rd_resp;

  // one write and one read outstanding at most
  assign wr_hs          = s_axil_awvalid & s_axil_wvalid & ~s_axil_bvalid;
  assign rd_hs          = s_axil_arvalid & ~s_axil_rvalid;
  assign s_axil_awready = wr_hs;
  assign s_axil_wready  = wr_hs;
  assign s_axil_arready = rd_hs;

  // ====================
  // address decode
  // ====================
  always_comb
  begin
    case (reg_addr_e'(s_axil_awaddr))
      REG_LED, REG_RESET_REQ: wr_resp = OKAY;
      default:                wr_resp = SLVERR;   // read only or unmapped
    endcase
  end

  always_comb
  begin
    rd_data = '0;
    rd_resp = OKAY;
    case (reg_addr_e'(s_axil_araddr))
      REG_LED:       rd_data = axil_data_t'(led);
      REG_SW:        rd_data = axil_data_t'(sw);
      REG_BUTTON:    rd_data = axil_data_t'(buttons);
      REG_RESET_REQ: rd_data = axil_data_t'(reset_req);
      default:       rd_resp = SLVERR;   // data stays 0
    endcase
  end

  // ====================
  // write channel
  // ====================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      led           <= '0;
      reset_req     <= '0;
      s_axil_bvalid <= 1'b0;
      s_axil_bresp  <= OKAY;
    end
    else if (wr_hs)
    begin
      s_axil_bvalid <= 1'b1;
      s_axil_bresp  <= wr_resp;
      case (reg_addr_e'(s_axil_awaddr))
        REG_LED:       led       <= s_axil_wdata[$bits(led_t)-1:0];
        REG_RESET_REQ: reset_req <= s_axil_wdata[$bits(reset_req_t)-1:0];
        default:       ;   // nothing changes
      endcase
    end
    else if (s_axil_bready)
      s_axil_bvalid <= 1'b0;   // resp taken, or nothing pending
  end

  // ====================
  // read channel
  // ====================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      s_axil_rvalid <= 1'b0;
      s_axil_rresp  <= OKAY;
    end
    else if (rd_hs)
    begin
      s_axil_rvalid <= 1'b1;
      s_axil_rresp  <= rd_resp;
    end
    else if (s_axil_rready)
      s_axil_rvalid <= 1'b0;
  end

  // read data held with rvalid
  always_ff @(posedge fpga_clk_50)
  begin
    if (rd_hs)
      s_axil_rdata <= rd_data;
  end

endmodule

`default_nettype wire

// ==== src/reset_req_pulse.sv ====
`default_nettype none

module reset_req_pulse #(
  parameter int pulse_cycles = ghrd_pkg::COLD_PULSE_CYCLES
) (
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  input  logic req,     // request level from register
  output logic pulse
);

  import ghrd_pkg::*;

  localparam int cnt_w = $clog2(pulse_cycles + 1);
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(pulse_cycles - 1);

  logic             req_q;
  logic             req_d;   // previous req_q
  logic             rise;
  pulse_state_e     state;
  logic [cnt_w-1:0] cnt;

  assign rise  = req_q & ~req_d;
  assign pulse = (state == BUSY);

  // ====================
  // edge detect
  // ====================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      req_q <= 1'b0;
      req_d <= 1'b0;
    end
    else
    begin
      req_q <= req;
      req_d <= req_q;
    end
  end

  // ====================
  // pulse stretch
  // ====================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      state <= IDLE;
      cnt   <= '0;
    end
    else
    begin
      case (state)
        IDLE:
        begin
          cnt <= '0;
          if (rise)
            state <= BUSY;
        end
        BUSY:
        begin
          // edges here are dropped
          if (cnt == cnt_last)
            state <= IDLE;
          else
            cnt <= cnt + 1'b1;
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== test/ghrd_checker.sv ====
`default_nettype none

module ghrd_checker #(
  parameter int pulse_cycles = 1
) (
  input logic                 fpga_clk_50,
  input logic                 hps_fpga_reset_n,
  input logic                 bvalid,
  input logic                 bready,
  input ghrd_pkg::axil_resp_e bresp,
  input logic                 rvalid,
  input logic                 rready,
  input ghrd_pkg::axil_data_t rdata,
  input logic                 pulse
);

  int fails = 0;   // assertion failures so far

  // ====================
  // bus response hold
  // ====================
  bresp_held: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else
    begin
      fails++;
      $error("write response not held until bready");
    end

  rdata_held: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else
    begin
      fails++;
      $error("read response not held until rready");
    end

  // stretcher never overruns its width
  pulse_len: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    $rose(pulse) |-> ##[1:pulse_cycles] !pulse)
    else
    begin
      fails++;
      $error("reset pulse high longer than %0d cycles", pulse_cycles);
    end

endmodule

// ====================
// bind points
// ====================
bind pio_axil_regs ghrd_checker bus_checker_i (
  .fpga_clk_50      (fpga_clk_50),
  .hps_fpga_reset_n (hps_fpga_reset_n),
  .bvalid           (s_axil_bvalid),
  .bready           (s_axil_bready),
  .bresp            (s_axil_bresp),
  .rvalid           (s_axil_rvalid),
  .rready           (s_axil_rready),
  .rdata            (s_axil_rdata),
  .pulse            (1'b0)            // no pulse here
);

bind reset_req_pulse ghrd_checker #(.pulse_cycles(pulse_cycles)) pulse_checker_i (
  .fpga_clk_50      (fpga_clk_50),
  .hps_fpga_reset_n (hps_fpga_reset_n),
  .bvalid           (1'b0),           // bus side idle
  .bready           (1'b1),
  .bresp            (ghrd_pkg::OKAY),
  .rvalid           (1'b0),
  .rready           (1'b1),
  .rdata            ('0),
  .pulse            (pulse)
);

`default_nettype wire

// ==== test/tb_fpga_ghrd_top.sv ====
`default_nettype none

module tb_fpga_ghrd_top;

  import ghrd_pkg::*;

  localparam int tb_debounce = 8;
  localparam int tb_hb_half  = 20;

  typedef enum {OP_WRITE, OP_READ, OP_SW, OP_KEY, OP_PULSE, OP_HB} op_e;

  typedef struct {
    op_e        op;
    axil_addr_t addr;
    axil_data_t data;    // write data or raw key level
    logic       rnd;     // take data from the lfsr
    axil_resp_e resp;
    int         hold;    // bready/rready stall, or glitch length
    key_t       exp;     // expected buttons
    int         bound;   // cycles this step may take
  } step_t;

  logic                fpga_clk_50;
  logic                hps_fpga_reset_n;
  key_t                key;
  sw_t                 sw;
  logic [$bits(led_t):0] ledr;
  stm_events_t         stm_events;
  logic                cold_reset_req;
  logic                warm_reset_req;
  logic                debug_reset_req;
  axil_addr_t          s_axil_awaddr;
  logic                s_axil_awvalid;
  logic                s_axil_awready;
  axil_data_t          s_axil_wdata;
  logic                s_axil_wvalid;
  logic                s_axil_wready;
  axil_resp_e          s_axil_bresp;
  logic                s_axil_bvalid;
  logic                s_axil_bready;
  axil_addr_t          s_axil_araddr;
  logic                s_axil_arvalid;
  logic                s_axil_arready;
  axil_data_t          s_axil_rdata;
  axil_resp_e          s_axil_rresp;
  logic                s_axil_rvalid;
  logic                s_axil_rready;

  step_t       steps[$];
  int          errors      = 0;
  int          cycle_cnt   = 0;
  int          cycle_limit = 0;
  logic [15:0] lfsr_state  = 16'd62;
  led_t        led_model   = '0;   // expected register state
  sw_t         sw_model    = '0;
  key_t        btn_model   = '0;
  reset_req_t  req_model   = '0;

  fpga_ghrd_top #(
    .debounce_cycles (tb_debounce),
    .hb_half_period  (tb_hb_half)
  ) fpga_ghrd_top_i (.*);

  initial
  begin
    fpga_clk_50 = 1'b0;
    forever #20 fpga_clk_50 = ~fpga_clk_50;   // 40 unit period
  end

  // run limit from the table bounds
  always @(posedge fpga_clk_50)
  begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit)
    begin
      $display("timeout: run went past %0d cycles without finishing", cycle_limit);
      $display("TB FAILED");
      $finish;
    end
  end

  // ====================
  // lfsr and models
  // ====================
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // galois, taps 16 14 13 11
  endfunction

  task automatic rand_bits(input int n, output axil_data_t v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      v[i]       = lfsr_state[0];   // one step per bit
    end
  endtask

  function automatic axil_data_t expected_read(input axil_addr_t a);
    case (a)
      REG_LED:       return axil_data_t'(led_model);
      REG_SW:        return axil_data_t'(sw_model);
      REG_BUTTON:    return axil_data_t'(btn_model);
      REG_RESET_REQ: return axil_data_t'(req_model);
      default:       return '0;   // unmapped reads as zero
    endcase
  endfunction

  function automatic int pulse_width(input int kind);
    case (kind)
      REQ_COLD: return COLD_PULSE_CYCLES;
      REQ_WARM: return WARM_PULSE_CYCLES;
      default:  return DEBUG_PULSE_CYCLES;
    endcase
  endfunction

  // ====================
  // compare tasks
  // ====================
  task automatic check_data(input string name, input axil_data_t got, input axil_data_t exp);
    if (got !== exp)
    begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_resp(input string name, input axil_resp_e got, input axil_resp_e exp);
    if (got !== exp)
    begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_buttons(input string name, input key_t got, input key_t exp);
    if (got !== exp)
    begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_width(input string name, input int got, input int exp);
    if (got != exp)
    begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  // led bits and trace word against the models
  task automatic check_pins;
    @(negedge fpga_clk_50);
    check_data("ledr[9:1]", axil_data_t'(ledr[9:1]), axil_data_t'(led_model));
    check_data("stm_events", axil_data_t'(stm_events),
               axil_data_t'({4'h0, sw_model, led_model, btn_model}));
  endtask

  // ====================
  // bus master
  // ====================
  task automatic bus_write(input axil_addr_t addr, input axil_data_t data, input int stall,
                           output axil_resp_e resp);
    @(posedge fpga_clk_50);
    s_axil_awaddr  <= addr;
    s_axil_awvalid <= 1'b1;
    s_axil_wdata   <= data;
    s_axil_wvalid  <= 1'b1;
    @(negedge fpga_clk_50);
    while (!(s_axil_awready && s_axil_wready))
      @(negedge fpga_clk_50);
    @(posedge fpga_clk_50);   // handshake edge
    s_axil_awvalid <= 1'b0;
    s_axil_wvalid  <= 1'b0;
    @(negedge fpga_clk_50);
    while (!s_axil_bvalid)
      @(negedge fpga_clk_50);
    resp = s_axil_bresp;
    repeat (stall)
    begin
      @(negedge fpga_clk_50);
      if (!s_axil_bvalid || s_axil_bresp !== resp)
      begin
        $display("write response was dropped or changed while bready was low");
        errors++;
      end
    end
    @(posedge fpga_clk_50);
    s_axil_bready <= 1'b1;
    @(posedge fpga_clk_50);   // slave sees bready here
    s_axil_bready <= 1'b0;
  endtask

  task automatic bus_read(input axil_addr_t addr, input int stall,
                          output axil_data_t data, output axil_resp_e resp);
    @(posedge fpga_clk_50);
    s_axil_araddr  <= addr;
    s_axil_arvalid <= 1'b1;
    @(negedge fpga_clk_50);
    while (!s_axil_arready)
      @(negedge fpga_clk_50);
    @(posedge fpga_clk_50);
    s_axil_arvalid <= 1'b0;
    @(negedge fpga_clk_50);
    while (!s_axil_rvalid)
      @(negedge fpga_clk_50);
    data = s_axil_rdata;
    resp = s_axil_rresp;
    repeat (stall)
    begin
      @(negedge fpga_clk_50);
      if (!s_axil_rvalid || s_axil_rdata !== data || s_axil_rresp !== resp)
      begin
        $display("read response was dropped or changed while rready was low");
        errors++;
      end
    end
    @(posedge fpga_clk_50);
    s_axil_rready <= 1'b1;
    @(posedge fpga_clk_50);
    s_axil_rready <= 1'b0;
  endtask

  task automatic add_step(input op_e op, input axil_addr_t addr, input axil_data_t data,
                          input logic rnd, input axil_resp_e resp, input int hold,
                          input key_t exp, input int bound);
    step_t s;
    s = '{op, addr, data, rnd, resp, hold, exp, bound};
    steps.push_back(s);
  endtask

  // ====================
  // stimulus table
  // ====================
  task automatic build_table;
    add_step(OP_WRITE, REG_LED, '0, 1'b1, OKAY, 0, '0, 12);
    add_step(OP_READ, REG_LED, '0, 1'b0, OKAY, 0, '0, 12);
    add_step(OP_WRITE, REG_LED, '0, 1'b1, OKAY, 3, '0, 15);   // bready held low
    add_step(OP_READ, REG_LED, '0, 1'b0, OKAY, 4, '0, 16);    // rready held low
    add_step(OP_SW, '0, '0, 1'b0, OKAY, 0, '0, 4);
    add_step(OP_READ, REG_SW, '0, 1'b0, OKAY, 0, '0, 12);
    add_step(OP_SW, '0, '0, 1'b0, OKAY, 0, '0, 4);
    add_step(OP_READ, REG_SW, '0, 1'b0, OKAY, 0, '0, 12);
    add_step(OP_KEY, '0, 32'hE, 1'b0, OKAY, 0, 4'h1, 30);     // press key 0
    add_step(OP_KEY, '0, 32'hC, 1'b0, OKAY, 4, 4'h1, 40);     // short glitch on key 1
    add_step(OP_READ, REG_BUTTON, '0, 1'b0, OKAY, 0, '0, 12);
    add_step(OP_KEY, '0, 32'hF, 1'b0, OKAY, 0, 4'h0, 30);
    add_step(OP_KEY, '0, 32'h7, 1'b0, OKAY, 0, 4'h8, 30);
    add_step(OP_READ, REG_BUTTON, '0, 1'b0, OKAY, 0, '0, 12);
    add_step(OP_PULSE, REG_RESET_REQ, 32'h1, 1'b0, OKAY, 0, '0, 50);
    add_step(OP_PULSE, REG_RESET_REQ, 32'h3, 1'b0, OKAY, 0, '0, 50);
    add_step(OP_PULSE, REG_RESET_REQ, 32'h7, 1'b0, OKAY, 0, '0, 50);
    add_step(OP_PULSE, REG_RESET_REQ, 32'h7, 1'b0, OKAY, 0, '0, 50);   // already set
    add_step(OP_PULSE, REG_RESET_REQ, 32'h0, 1'b0, OKAY, 0, '0, 50);   // falling only
    add_step(OP_PULSE, REG_RESET_REQ, 32'h2, 1'b0, OKAY, 0, '0, 50);
    add_step(OP_READ, REG_RESET_REQ, '0, 1'b0, OKAY, 0, '0, 12);
    add_step(OP_READ, 4'h2, '0, 1'b0, SLVERR, 3, '0, 15);
    add_step(OP_READ, 4'hD, '0, 1'b0, SLVERR, 0, '0, 12);
    add_step(OP_WRITE, REG_SW, '0, 1'b1, SLVERR, 2, '0, 14);
    add_step(OP_WRITE, 4'h6, 32'h1FF, 1'b0, SLVERR, 0, '0, 12);
    add_step(OP_READ, REG_SW, '0, 1'b0, OKAY, 0, '0, 12);
    add_step(OP_READ, REG_LED, '0, 1'b0, OKAY, 0, '0, 12);
    add_step(OP_HB, '0, '0, 1'b0, OKAY, 0, '0, 50);
  endtask

  initial
  begin
    step_t      s;
    axil_data_t data;
    axil_data_t rd;
    axil_resp_e resp;
    key_t       key_level;
    int         err_before;
    int         widths[3];
    int         n;
    logic       hb_prev;

    // idle bus, keys released
    hps_fpga_reset_n <= 1'b0;
    key              <= '1;
    sw               <= '0;
    s_axil_awaddr    <= '0;
    s_axil_awvalid   <= 1'b0;
    s_axil_wdata     <= '0;
    s_axil_wvalid    <= 1'b0;
    s_axil_bready    <= 1'b0;
    s_axil_araddr    <= '0;
    s_axil_arvalid   <= 1'b0;
    s_axil_rready    <= 1'b0;
    key_level = '1;
    build_table();
    cycle_limit = 100;
    foreach (steps[i])
      cycle_limit += steps[i].bound;

    repeat (3) @(posedge fpga_clk_50);
    hps_fpga_reset_n <= 1'b1;
    @(negedge fpga_clk_50);
    check_data("ledr", axil_data_t'(ledr), '0);   // heartbeat starts low
    check_data("stm_events", axil_data_t'(stm_events), '0);
    check_width("reset request lines", cold_reset_req + warm_reset_req + debug_reset_req, 0);
    check_data("bus valid and ready", axil_data_t'({s_axil_awready, s_axil_wready,
               s_axil_arready, s_axil_bvalid, s_axil_rvalid}), '0);

    foreach (steps[i])
    begin
      s          = steps[i];
      err_before = errors;
      data       = s.data;
      if (s.rnd)
        rand_bits(32, data);
      case (s.op)
        OP_WRITE:
        begin
          bus_write(s.addr, data, s.hold, resp);
          check_resp("bresp", resp, s.resp);
          case (s.addr)
            REG_LED:       led_model = led_t'(data);
            REG_RESET_REQ: req_model = reset_req_t'(data);
            default:       ;   // read only or unmapped
          endcase
          check_pins();
        end
        OP_READ:
        begin
          bus_read(s.addr, s.hold, rd, resp);
          check_data("rdata", rd, expected_read(s.addr));
          check_resp("rresp", resp, s.resp);
          check_pins();
        end
        OP_SW:
        begin
          rand_bits($bits(sw_t), data);
          @(posedge fpga_clk_50);
          sw       <= sw_t'(data);
          sw_model = sw_t'(data);
          check_pins();
        end
        OP_KEY:
        begin
          @(posedge fpga_clk_50);
          key <= key_t'(data);
          if (s.hold > 0)
          begin
            // glitch, then back to the steady level
            repeat (s.hold) @(posedge fpga_clk_50);
            key <= key_level;
            repeat (3 * tb_debounce) @(negedge fpga_clk_50);
          end
          else
          begin
            key_level = key_t'(data);
            n = 0;
            while (stm_events[3:0] !== s.exp && n < s.bound)
            begin
              @(negedge fpga_clk_50);
              n++;
            end
          end
          check_buttons("buttons", stm_events[3:0], s.exp);
          btn_model = s.exp;
        end
        OP_PULSE:
        begin
          widths = '{0, 0, 0};
          fork
            bus_write(s.addr, data, 0, resp);
            repeat (44)
            begin
              @(negedge fpga_clk_50);
              widths[REQ_COLD]  += cold_reset_req;
              widths[REQ_WARM]  += warm_reset_req;
              widths[REQ_DEBUG] += debug_reset_req;
            end
          join
          check_resp("bresp", resp, OKAY);
          for (int k = 0; k < 3; k++)
          begin
            // only a 0 to 1 change of the request bit fires
            check_width($sformatf("reset pulse width bit %0d", k), widths[k],
                        (data[k] && !req_model[k]) ? pulse_width(k) : 0);
          end
          req_model = reset_req_t'(data);
        end
        OP_HB:
        begin
          @(negedge fpga_clk_50);
          hb_prev = ledr[0];
          while (ledr[0] == hb_prev)
            @(negedge fpga_clk_50);
          n       = 0;
          hb_prev = ledr[0];
          while (ledr[0] == hb_prev)
          begin
            @(negedge fpga_clk_50);
            n++;
          end
          check_width("heartbeat half period", n, tb_hb_half);
        end
        default: ;
      endcase
      $display("test %0d %s: %s", i, s.op.name(), (errors == err_before) ? "ok" : "failed");
    end

    // bound assertion failures
    errors += fpga_ghrd_top_i.pio_axil_regs_i.bus_checker_i.fails;
    errors += fpga_ghrd_top_i.cold_pulse_i.pulse_checker_i.fails;
    errors += fpga_ghrd_top_i.warm_pulse_i.pulse_checker_i.fails;
    errors += fpga_ghrd_top_i.debug_pulse_i.pulse_checker_i.fails;

    $display("%0d tests run, %0d errors", steps.size(), errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire
